// File: hdl/gamePkg.sv
// Game widths, level constants, play sequence table and controller state type

package gamePkg;

    // One LED or key per bit, one-hot for a real play
    typedef logic [3:0] playT;

    // Sequence index, doubles as the round number
    typedef logic [3:0] addrT;

    // Entries in the fixed sequence
    localparam int seqLen = 16;

    // Rounds played at the easy length level
    // Hard level runs the whole sequence
    localparam int easyRounds = 8;

    // Fixed sequence shown on the LEDs
    localparam playT playSequence [seqLen] = '{
        4'b0001, 4'b0010, 4'b0100, 4'b1000,
        4'b0100, 4'b0010, 4'b0001, 4'b0001,
        4'b0010, 4'b0010, 4'b0100, 4'b0100,
        4'b1000, 4'b1000, 4'b0001, 4'b0100
    };

    // Controller states
    typedef enum logic [3:0] {
        idle,
        prepare,
        showPlay,
        nextShow,
        waitPlay,
        registerPlay,
        comparePlay,
        nextAddress,
        nextRound,
        endWon,
        endLost,
        endTimeout
    } gameStateT;

endpackage

// File: hdl/timerPkg.sv
// Tick counts and counter widths for the show and reply timeout timers

package timerPkg;

    // One show slot at the 1 kHz board clock
    // Lit for the first half, dark for the second
    localparam int showTicks = 1000;

    // Show counter width, holds up to showTicks-1
    localparam int showWidth = 10;

    // Reply timeout at the easy time level
    // Hard level stops at half of this count
    localparam int timeoutTicks = 3000;

    // Timeout counter width, holds up to timeoutTicks-1
    localparam int timeoutWidth = 12;

endpackage

// File: hdl/moduloCounter.sv
// Modulo counter with asynchronous and synchronous clear, end and half flags

`timescale 1ns/1ps

module moduloCounter #(
    parameter int modulus = 16,
    parameter int width = 4
) (
    input  logic             clock,
    input  logic             rstN,
    // Clears at once, outside the clock
    input  logic             clearAsync,
    // Clears on the next clock edge
    input  logic             clearSync,
    input  logic             count,
    output logic [width-1:0] value,
    output logic             atEnd,
    output logic             atHalf
);

    // Reset and asynchronous clear share the flop clear pin
    logic clearN;

    assign clearN = rstN & ~clearAsync;

    always_ff @(posedge clock or negedge clearN) begin
        if (!clearN) begin
            value <= '0;
        end else if (clearSync) begin
            value <= '0;
        end else if (count) begin
            // Wrap after the last value
            if (value == width'(modulus - 1)) begin
                value <= '0;
            end else begin
                value <= value + 1'b1;
            end
        end
    end

    // Flags follow the count directly
    assign atEnd  = (value == width'(modulus - 1));
    assign atHalf = (value >= width'(modulus / 2));

endmodule

// File: hdl/gameDatapath.sv
// Game datapath with level and play registers, key edge detector, sequence lookup,
// address, round and timer counters and the comparisons for the controller

`timescale 1ns/1ps

module gameDatapath (
    input  logic          clock,
    input  logic          rstN,

    // Player inputs
    input  gamePkg::playT keys,
    // High selects 16 rounds, low selects 8
    input  logic          levelRounds,
    // High selects the short timeout
    input  logic          levelTime,

    // Controller phase
    input  logic          showing,
    input  logic          waiting,

    // Control strobes
    input  logic          clearLevels,
    input  logic          loadLevels,
    input  logic          clearPlay,
    input  logic          loadPlay,
    input  logic          clearAddr,
    input  logic          countAddr,
    input  logic          clearRound,
    input  logic          countRound,
    input  logic          clearShow,
    input  logic          countShow,
    input  logic          clearTimeout,
    input  logic          countTimeout,

    // Conditions back to the controller
    output logic          playMade,
    output logic          playCorrect,
    output logic          addrEqRound,
    output logic          lastRound,
    output logic          showEnd,
    output logic          showHalf,
    output logic          timeoutEnd,

    // Board outputs
    output gamePkg::playT leds,
    output gamePkg::addrT round
);

    // Latched levels
    logic levelRoundsReg;
    logic levelTimeReg;

    // Registered player key pattern
    gamePkg::playT play;

    // Key edge detector
    logic anyKey;
    logic anyKeyPrev;

    // Sequence lookup
    gamePkg::addrT addr;
    gamePkg::playT seqEntry;

    // Timeout flags before level selection
    logic timeoutFull;
    logic timeoutHalf;

    // Levels are latched once per game
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            levelRoundsReg <= 1'b0;
            levelTimeReg   <= 1'b0;
        end else if (clearLevels) begin
            levelRoundsReg <= 1'b0;
            levelTimeReg   <= 1'b0;
        end else if (loadLevels) begin
            levelRoundsReg <= levelRounds;
            levelTimeReg   <= levelTime;
        end
    end

    // Play register, loaded while keys are still held
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            play <= '0;
        end else if (clearPlay) begin
            play <= '0;
        end else if (loadPlay) begin
            play <= keys;
        end
    end

    // Pulse on zero to nonzero change of the keys
    assign anyKey = |keys;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            anyKeyPrev <= 1'b0;
        end else begin
            anyKeyPrev <= anyKey;
        end
    end

    assign playMade = anyKey & ~anyKeyPrev;

    // Registered lookup, one cycle behind the address
    always_ff @(posedge clock) begin
        seqEntry <= gamePkg::playSequence[addr];
    end

    // Position inside the current round
    moduloCounter #(.modulus(gamePkg::seqLen), .width($bits(gamePkg::addrT))) addrCounter (
        .clock      (clock),
        .rstN       (rstN),
        .clearAsync (1'b0),
        .clearSync  (clearAddr),
        .count      (countAddr),
        .value      (addr),
        .atEnd      (),
        .atHalf     ()
    );

    // Current round number
    moduloCounter #(.modulus(gamePkg::seqLen), .width($bits(gamePkg::addrT))) roundCounter (
        .clock      (clock),
        .rstN       (rstN),
        .clearAsync (1'b0),
        .clearSync  (clearRound),
        .count      (countRound),
        .value      (round),
        .atEnd      (),
        .atHalf     ()
    );

    // Show slot timer
    moduloCounter #(.modulus(timerPkg::showTicks), .width(timerPkg::showWidth)) showTimer (
        .clock      (clock),
        .rstN       (rstN),
        .clearAsync (1'b0),
        .clearSync  (clearShow),
        .count      (countShow),
        .value      (),
        .atEnd      (showEnd),
        .atHalf     (showHalf)
    );

    // Reply timer, restarted by every new key press
    moduloCounter #(.modulus(timerPkg::timeoutTicks), .width(timerPkg::timeoutWidth)) timeoutTimer (
        .clock      (clock),
        .rstN       (rstN),
        .clearAsync (playMade),
        .clearSync  (clearTimeout),
        .count      (countTimeout),
        .value      (),
        .atEnd      (timeoutFull),
        .atHalf     (timeoutHalf)
    );

    // Comparisons
    assign playCorrect = (seqEntry == play);
    assign addrEqRound = (addr == round);

    // Final round depends on the length level
    assign lastRound = levelRoundsReg ? (round == gamePkg::addrT'(gamePkg::seqLen - 1))
                                      : (round == gamePkg::addrT'(gamePkg::easyRounds - 1));

    // Short timeout stops at half count
    assign timeoutEnd = levelTimeReg ? timeoutHalf : timeoutFull;

    // Lit half of a show slot, echo of the play while waiting, dark otherwise
    always_comb begin
        if (showing && !showHalf) begin
            leds = seqEntry;
        end else if (waiting) begin
            leds = play;
        end else begin
            leds = '0;
        end
    end

endmodule

// File: hdl/gameController.sv
// Game FSM producing the datapath strobes, phase outputs and result flags

`timescale 1ns/1ps

module gameController (
    input  logic clock,
    input  logic rstN,
    input  logic start,

    // Conditions from the datapath
    input  logic playMade,
    input  logic playCorrect,
    input  logic addrEqRound,
    input  logic lastRound,
    input  logic showEnd,
    input  logic showHalf,
    input  logic timeoutEnd,

    // Datapath strobes
    output logic clearLevels,
    output logic loadLevels,
    output logic clearPlay,
    output logic loadPlay,
    output logic clearAddr,
    output logic countAddr,
    output logic clearRound,
    output logic countRound,
    output logic clearShow,
    output logic countShow,
    output logic clearTimeout,
    output logic countTimeout,

    // Phase and result
    output logic showing,
    output logic waiting,
    output logic won,
    output logic lost,
    output logic timedOut
);

    gamePkg::gameStateT state;
    gamePkg::gameStateT nextState;

    // Start only counts from idle or a finished game
    logic canStart;

    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            state <= gamePkg::idle;
        end else begin
            state <= nextState;
        end
    end

    assign canStart = (state == gamePkg::idle) || (state == gamePkg::endWon)
                   || (state == gamePkg::endLost) || (state == gamePkg::endTimeout);

    always_comb begin
        nextState    = state;
        clearLevels  = 1'b0;
        loadLevels   = 1'b0;
        clearPlay    = 1'b0;
        loadPlay     = 1'b0;
        clearAddr    = 1'b0;
        countAddr    = 1'b0;
        clearRound   = 1'b0;
        countRound   = 1'b0;
        clearShow    = 1'b0;
        countShow    = 1'b0;
        clearTimeout = 1'b1;
        countTimeout = 1'b0;

        case (state)
            gamePkg::idle: begin
                clearLevels = 1'b1;
                clearAddr   = 1'b1;
            end
            gamePkg::prepare: begin
                loadLevels = 1'b1;
                clearPlay  = 1'b1;
                clearAddr  = 1'b1;
                clearRound = 1'b1;
                clearShow  = 1'b1;
                nextState  = gamePkg::showPlay;
            end
            gamePkg::showPlay: begin
                countShow = 1'b1;
                if (showEnd) begin
                    // Slot for the round's last play ends the show
                    if (addrEqRound) begin
                        clearAddr = 1'b1;
                        nextState = gamePkg::waitPlay;
                    end else begin
                        countAddr = 1'b1;
                        nextState = gamePkg::nextShow;
                    end
                end
            end
            // Lookup catches up with the new address
            gamePkg::nextShow: begin
                nextState = gamePkg::showPlay;
            end
            gamePkg::waitPlay: begin
                clearTimeout = 1'b0;
                countTimeout = 1'b1;
                if (playMade) begin
                    nextState = gamePkg::registerPlay;
                end else if (timeoutEnd) begin
                    nextState = gamePkg::endTimeout;
                end
            end
            gamePkg::registerPlay: begin
                loadPlay  = 1'b1;
                nextState = gamePkg::comparePlay;
            end
            gamePkg::comparePlay: begin
                if (!playCorrect) begin
                    nextState = gamePkg::endLost;
                end else if (addrEqRound) begin
                    // Address parks at zero ahead of the next show
                    clearAddr = 1'b1;
                    nextState = lastRound ? gamePkg::endWon : gamePkg::nextRound;
                end else begin
                    nextState = gamePkg::nextAddress;
                end
            end
            gamePkg::nextAddress: begin
                countAddr = 1'b1;
                nextState = gamePkg::waitPlay;
            end
            gamePkg::nextRound: begin
                countRound = 1'b1;
                clearPlay  = 1'b1;
                clearShow  = 1'b1;
                nextState  = gamePkg::showPlay;
            end
            // End states keep address at zero so a new game shows entry 0 at once
            gamePkg::endWon, gamePkg::endLost, gamePkg::endTimeout: begin
                clearAddr = 1'b1;
            end
            default: begin
                nextState = gamePkg::idle;
            end
        endcase

        if (canStart && start) begin
            nextState = gamePkg::prepare;
        end
    end

    // Moore outputs
    assign showing  = (state == gamePkg::showPlay);
    assign waiting  = (state == gamePkg::waitPlay);
    assign won      = (state == gamePkg::endWon);
    assign lost     = (state == gamePkg::endLost);
    assign timedOut = (state == gamePkg::endTimeout);

endmodule

// File: hdl/memoryGame.sv
// Memory game top with controller and datapath

`timescale 1ns/1ps

module memoryGame (
    input  logic          clock,
    input  logic          rstN,
    input  logic          start,
    input  gamePkg::playT keys,
    // High for 16 rounds
    input  logic          levelRounds,
    // High for the short reply timeout
    input  logic          levelTime,
    output gamePkg::playT leds,
    output gamePkg::addrT round,
    output logic          won,
    output logic          lost,
    output logic          timedOut
);

    // Control strobes
    logic clearLevels;
    logic loadLevels;
    logic clearPlay;
    logic loadPlay;
    logic clearAddr;
    logic countAddr;
    logic clearRound;
    logic countRound;
    logic clearShow;
    logic countShow;
    logic clearTimeout;
    logic countTimeout;

    // Phase
    logic showing;
    logic waiting;

    // Conditions
    logic playMade;
    logic playCorrect;
    logic addrEqRound;
    logic lastRound;
    logic showEnd;
    logic showHalf;
    logic timeoutEnd;

    gameController controller (
        .clock, .rstN, .start,
        .playMade, .playCorrect, .addrEqRound, .lastRound,
        .showEnd, .showHalf, .timeoutEnd,
        .clearLevels, .loadLevels, .clearPlay, .loadPlay,
        .clearAddr, .countAddr, .clearRound, .countRound,
        .clearShow, .countShow, .clearTimeout, .countTimeout,
        .showing, .waiting, .won, .lost, .timedOut
    );

    gameDatapath datapath (
        .clock, .rstN, .keys, .levelRounds, .levelTime,
        .showing, .waiting,
        .clearLevels, .loadLevels, .clearPlay, .loadPlay,
        .clearAddr, .countAddr, .clearRound, .countRound,
        .clearShow, .countShow, .clearTimeout, .countTimeout,
        .playMade, .playCorrect, .addrEqRound, .lastRound,
        .showEnd, .showHalf, .timeoutEnd,
        .leds, .round
    );

endmodule

// File: test/clockGen.sv
// Testbench clock and reset generator

`timescale 1ns/1ps

module clockGen (
    output logic clock,
    output logic rstN
);

    // 10 ns period
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Reset held low for 3 cycles, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clock);
        @(negedge clock);
        rstN = 1'b1;
    end

endmodule

// File: test/memoryGameTb.sv
// Memory game testbench with directed tests, player model and checks

`timescale 1ns/1ps

module memoryGameTb;

    // One show slot plus the nextShow cycle
    localparam int slotCycles = timerPkg::showTicks + 1;
    // Dark half of a show slot
    localparam int darkCycles = timerPkg::showTicks / 2;

    logic          clock;
    logic          rstN;
    logic          start;
    gamePkg::playT keys;
    logic          levelRounds;
    logic          levelTime;
    gamePkg::playT leds;
    gamePkg::addrT round;
    logic          won;
    logic          lost;
    logic          timedOut;

    // Wrong key generator state
    logic [31:0] rngState;

    clockGen clkGen (.clock, .rstN);

    memoryGame uut (
        .clock, .rstN, .start, .keys, .levelRounds, .levelTime,
        .leds, .round, .won, .lost, .timedOut
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // One of the three one-hot keys other than the expected one
    function automatic gamePkg::playT pickWrongKey(input gamePkg::playT expected);
        int            k;
        gamePkg::playT cand;
        gamePkg::playT result;
        rngState = xorshift(rngState);
        k = rngState % 3;
        result = '0;
        for (int i = 0; i < 4; i++) begin
            cand = 4'b0001 << i;
            if (cand != expected) begin
                if (k == 0 && result == '0) begin
                    result = cand;
                end
                k--;
            end
        end
        return result;
    endfunction

    // Result flags packed as won, lost, timedOut
    function automatic logic [2:0] resultFlags();
        return {won, lost, timedOut};
    endfunction

    task automatic stopOnFailure(input string reason);
        $display("%s", reason);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string testName, input string what,
                              input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            stopOnFailure($sformatf("ERROR %s %s: expected %0h, actual %0h",
                                    testName, what, expected, actual));
        end
    endtask

    // Levels set with the start pulse
    // Returns in the prepare cycle
    task automatic pulseStart(input logic rounds, input logic timeLevel);
        @(negedge clock);
        levelRounds = rounds;
        levelTime   = timeLevel;
        start       = 1'b1;
        @(negedge clock);
        start = 1'b0;
    endtask

    // Counts the lit slots of round r and returns once the wait has begun
    task automatic watchShow(input string testName, input int r);
        gamePkg::playT prev;
        int            lit;
        int            cycles;
        bit            dark;
        prev   = '0;
        lit    = 0;
        cycles = 0;
        dark   = 1'b0;
        while (!dark) begin
            @(negedge clock);
            cycles++;
            if (cycles > (r + 2) * slotCycles) begin
                stopOnFailure($sformatf("Show of round %0d never ended in %s", r, testName));
            end
            if (leds != '0 && prev == '0) begin
                checkValue(testName, "shown play", 32'(gamePkg::playSequence[lit]), 32'(leds));
                lit++;
            end else if (leds == '0 && prev != '0 && lit == r + 1) begin
                dark = 1'b1;
            end
            prev = leds;
        end
        // An extra slot would light up during the rest of the last slot
        repeat (darkCycles + 2) begin
            @(negedge clock);
            checkValue(testName, "leds after show", 0, 32'(leds));
        end
    endtask

    // Press held past the register cycle and then released
    task automatic pressKey(input gamePkg::playT key);
        @(negedge clock);
        keys = key;
        repeat (3) @(negedge clock);
        keys = '0;
        repeat (3) @(negedge clock);
    endtask

    task automatic waitForResult(input string testName, input logic [2:0] expected,
                                 input int limit);
        int cycles;
        cycles = 0;
        while (resultFlags() == 3'b000) begin
            @(negedge clock);
            cycles++;
            if (cycles > limit) begin
                stopOnFailure($sformatf("No game result within %0d cycles in %s",
                                        limit, testName));
            end
        end
        checkValue(testName, "result flags", 32'(expected), 32'(resultFlags()));
    endtask

    task automatic resetTest();
        int cycles;
        cycles = 0;
        while (rstN !== 1'b1) begin
            @(negedge clock);
            cycles++;
            if (cycles > 20) begin
                stopOnFailure("Reset never released");
            end
        end
        @(negedge clock);
        checkValue("reset", "result flags", 0, 32'(resultFlags()));
        checkValue("reset", "leds", 0, 32'(leds));
        checkValue("reset", "round", 0, 32'(round));
    endtask

    // Correct player through every round of the chosen length
    task automatic fullGameTest(input string testName, input logic hard);
        int rounds;
        rounds = hard ? gamePkg::seqLen : gamePkg::easyRounds;
        pulseStart(hard, 1'b0);
        for (int r = 0; r < rounds; r++) begin
            watchShow(testName, r);
            checkValue(testName, "round number", r, 32'(round));
            for (int n = 0; n <= r; n++) begin
                pressKey(gamePkg::playSequence[n]);
                // No verdict flag before the final play
                if (r < rounds - 1 || n < r) begin
                    checkValue(testName, "flags during game", 0, 32'(resultFlags()));
                end
            end
        end
        waitForResult(testName, 3'b100, 10);
        checkValue(testName, "round at win", rounds - 1, 32'(round));
    endtask

    task automatic wrongPlayTest();
        gamePkg::playT wrong;
        pulseStart(1'b0, 1'b0);
        for (int r = 0; r < 2; r++) begin
            watchShow("wrongPlay", r);
            for (int n = 0; n <= r; n++) begin
                pressKey(gamePkg::playSequence[n]);
            end
        end
        watchShow("wrongPlay", 2);
        pressKey(gamePkg::playSequence[0]);
        wrong = pickWrongKey(gamePkg::playSequence[1]);
        pressKey(wrong);
        waitForResult("wrongPlay", 3'b010, 10);
        // Restart clears the verdict and the round
        pulseStart(1'b0, 1'b0);
        @(negedge clock);
        checkValue("wrongPlay", "lost after restart", 0, 32'(lost));
        checkValue("wrongPlay", "round after restart", 0, 32'(round));
        // End the new game so the next start is honored
        watchShow("wrongPlay", 0);
        pressKey(pickWrongKey(gamePkg::playSequence[0]));
        waitForResult("wrongPlay", 3'b010, 10);
    endtask

    task automatic timeoutTest();
        int cycles;
        // Short reply time
        pulseStart(1'b0, 1'b1);
        watchShow("timeoutHard", 0);
        cycles = 0;
        while (!timedOut) begin
            @(negedge clock);
            cycles++;
            if (cycles > 2000) begin
                stopOnFailure("timedOut did not rise within 2000 cycles at the hard time level");
            end
        end
        checkValue("timeoutHard", "result flags", 32'(3'b001), 32'(resultFlags()));
        // Long reply time
        pulseStart(1'b0, 1'b0);
        watchShow("timeoutEasy", 0);
        repeat (2000) begin
            @(negedge clock);
            checkValue("timeoutEasy", "early timedOut", 0, 32'(timedOut));
        end
        cycles = 2000;
        while (!timedOut) begin
            @(negedge clock);
            cycles++;
            if (cycles > 3500) begin
                stopOnFailure("timedOut did not rise within 3500 cycles at the easy time level");
            end
        end
        checkValue("timeoutEasy", "result flags", 32'(3'b001), 32'(resultFlags()));
    endtask

    initial begin
        start       = 1'b0;
        keys        = '0;
        levelRounds = 1'b0;
        levelTime   = 1'b0;
        rngState    = 32'h4e73;
        resetTest();
        fullGameTest("easyLength", 1'b0);
        fullGameTest("hardLength", 1'b1);
        wrongPlayTest();
        timeoutTest();
        $display("Regression passed");
        $finish;
    end

endmodule

// File: compile.f
hdl/gamePkg.sv
hdl/timerPkg.sv
hdl/moduloCounter.sv
hdl/gameDatapath.sv
hdl/gameController.sv
hdl/memoryGame.sv
test/clockGen.sv
test/memoryGameTb.sv

// File: run.sh
#!/bin/sh
# Build and run the memory game testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f compile.f --top-module memoryGameTb -o memoryGameSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/memoryGameSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi

exit 0
